/* rtl/mem_geom_pkg.sv */
package mem_geom_pkg;

    // rv32 word, fixed since the half word rule assumes four lanes
    localparam int WORD_BYTES = 4;
    localparam int WORD_BITS  = WORD_BYTES * 8;   // 32

    // default array shape, top level passes these down as parameters
    localparam int DEF_DEPTH      = 256;   // rows
    localparam int DEF_LINE_WORDS = 4;     // words per row

    // byte offset field inside a word
    localparam int BYTE_OFF_BITS = $clog2(WORD_BYTES);

endpackage

/* rtl/mem_op_pkg.sv */
package mem_op_pkg;

    typedef enum logic [3:0] {
        op_none   = 4'd0,   // idle slot
        st_byte   = 4'd1,   // sb
        st_half   = 4'd2,   // sh
        st_word   = 4'd3,   // sw
        ld_byte_s = 4'd4,   // lb
        ld_byte_u = 4'd5,   // lbu
        ld_half_s = 4'd6,   // lh
        ld_half_u = 4'd7,   // lhu
        ld_word   = 4'd8    // lw
    } mem_op_t;

    function automatic logic op_is_store(input mem_op_t op);
        return (op == st_byte) || (op == st_half) || (op == st_word);
    endfunction

    function automatic logic op_is_load(input mem_op_t op);
        return (op == ld_byte_s) || (op == ld_byte_u) || (op == ld_half_s) ||
               (op == ld_half_u) || (op == ld_word);
    endfunction

    // access width in bytes, zero for op_none
    function automatic logic [2:0] op_size_bytes(input mem_op_t op);
        case (op)
            st_byte, ld_byte_s, ld_byte_u: return 3'd1;
            st_half, ld_half_s, ld_half_u: return 3'd2;
            st_word, ld_word:              return 3'd4;
            default:                       return 3'd0;
        endcase
    endfunction

    // only lb and lh sign extend
    function automatic logic op_is_signed(input mem_op_t op);
        return (op == ld_byte_s) || (op == ld_half_s);
    endfunction

endpackage

/* rtl/mem_req_if.sv */
`timescale 1ns/1ps

// decoded request from access_decode to byte_lane_ram
interface mem_req_if #(
    parameter int DEPTH      = mem_geom_pkg::DEF_DEPTH,
    parameter int LINE_WORDS = mem_geom_pkg::DEF_LINE_WORDS
);

    localparam int ROW_W  = $clog2(DEPTH);        // row index width
    localparam int WORD_W = $clog2(LINE_WORDS);   // word in row width

    logic                                valid;     // request present this cycle
    logic [ROW_W-1:0]                    row;       // addressed row
    logic [WORD_W-1:0]                   word;      // word within the row
    logic [mem_geom_pkg::WORD_BYTES-1:0] byte_en;   // per lane write enable
    logic [mem_geom_pkg::WORD_BITS-1:0]  wdata;     // store data already on its lanes
    logic                                rd;        // read strobe for loads

    modport decode_mp (
        output valid,
        output row,
        output word,
        output byte_en,
        output wdata,
        output rd
    );

    modport ram_mp (
        input valid,
        input row,
        input word,
        input byte_en,
        input wdata,
        input rd
    );

endinterface

/* rtl/access_decode.sv */
`timescale 1ns/1ps

module access_decode #(
    parameter int DEPTH      = mem_geom_pkg::DEF_DEPTH,
    parameter int LINE_WORDS = mem_geom_pkg::DEF_LINE_WORDS,
    localparam int ROW_W     = $clog2(DEPTH),
    localparam int WORD_W    = $clog2(LINE_WORDS),
    localparam int ADDR_W    = ROW_W + WORD_W + mem_geom_pkg::BYTE_OFF_BITS
) (
    input  logic                               req_valid,
    input  mem_op_pkg::mem_op_t                req_op,
    input  logic [ADDR_W-1:0]                  req_addr,
    input  logic [mem_geom_pkg::WORD_BITS-1:0] req_wdata,
    mem_req_if.decode_mp                       req,
    output logic                               ld_valid,
    output mem_op_pkg::mem_op_t                ld_op,
    output logic [1:0]                         ld_byte_offset,
    output logic                               ld_misaligned
);

    logic [ROW_W-1:0]                    row;          // row field of the address
    logic [WORD_W-1:0]                   word;         // word field
    logic [1:0]                          byte_off;     // byte inside the word
    logic [2:0]                          size;         // access size in bytes
    logic [1:0]                          align_mask;   // offset bits that must be zero
    logic                                is_store;
    logic                                is_load;
    logic                                misaligned;
    logic [mem_geom_pkg::WORD_BYTES-1:0] lane_mask;    // lanes touched at offset zero

    // little endian split, row on top and byte offset at the bottom
    assign {row, word, byte_off} = req_addr;

    assign is_store = mem_op_pkg::op_is_store(req_op);
    assign is_load  = mem_op_pkg::op_is_load(req_op);
    assign size     = mem_op_pkg::op_size_bytes(req_op);

    // half word needs bit 0 clear, word needs both bits clear
    assign align_mask = 2'(size - 3'd1);
    assign misaligned = (is_store || is_load) && ((byte_off & align_mask) != 2'b00);

    always_comb begin
        unique case (size)
            3'd1:    lane_mask = 4'b0001;   // byte
            3'd2:    lane_mask = 4'b0011;   // half word
            3'd4:    lane_mask = 4'b1111;   // full word
            default: lane_mask = 4'b0000;   // op_none touches nothing
        endcase
    end

    assign req.valid = req_valid;
    assign req.row   = row;
    assign req.word  = word;

    // a misaligned store gets no enables so memory stays untouched
    always_comb begin
        req.byte_en = '0;
        if (req_valid && is_store && !misaligned) begin
            req.byte_en = lane_mask << byte_off;
        end
    end

    assign req.wdata = req_wdata << {byte_off, 3'b000};   // move store data onto its lanes
    assign req.rd    = req_valid && is_load;              // misaligned loads read too, zeroed later

    // load side control, every valid request goes through so stores can flag misalignment
    assign ld_valid       = req_valid;
    assign ld_op          = req_op;
    assign ld_byte_offset = byte_off;
    assign ld_misaligned  = misaligned;

endmodule

/* rtl/byte_lane_ram.sv */
`timescale 1ns/1ps

module byte_lane_ram #(
    parameter int DEPTH      = mem_geom_pkg::DEF_DEPTH,
    parameter int LINE_WORDS = mem_geom_pkg::DEF_LINE_WORDS
) (
    input  logic                               clk,
    mem_req_if.ram_mp                          req,
    output logic [mem_geom_pkg::WORD_BITS-1:0] rdata
);

    // rows of words, each word four byte lanes, lane 0 is the lowest byte
    //
    //   row r : | word N-1 | ... | word 1 | word 0 |
    //   word  : | lane 3 | lane 2 | lane 1 | lane 0 |
    logic [7:0] mem [DEPTH][LINE_WORDS][mem_geom_pkg::WORD_BYTES];

    // lane writes, each enabled byte updates on its own
    always_ff @(posedge clk) begin
        if (req.valid) begin
            for (int b = 0; b < mem_geom_pkg::WORD_BYTES; b++) begin
                if (req.byte_en[b]) begin
                    mem[req.row][req.word][b] <= req.wdata[8*b +: 8];
                end
            end
        end
    end

    // registered word read, old data on a same edge write
    always_ff @(posedge clk) begin
        if (req.valid && req.rd) begin
            for (int b = 0; b < mem_geom_pkg::WORD_BYTES; b++) begin
                rdata[8*b +: 8] <= mem[req.row][req.word][b];   // assemble lanes little endian
            end
        end
    end

endmodule

/* rtl/load_extend.sv */
`timescale 1ns/1ps

module load_extend (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               ld_valid,
    input  mem_op_pkg::mem_op_t                ld_op,
    input  logic [1:0]                         ld_byte_offset,
    input  logic                               ld_misaligned,
    input  logic [mem_geom_pkg::WORD_BITS-1:0] rdata,
    output logic                               rsp_valid,
    output logic [mem_geom_pkg::WORD_BITS-1:0] rsp_rdata,
    output logic                               rsp_misaligned
);

    localparam int WB = mem_geom_pkg::WORD_BITS;

    logic                valid_q;     // request issued last edge
    logic                mis_q;       // it was misaligned
    mem_op_pkg::mem_op_t op_q;        // its operation
    logic [1:0]          off_q;       // its byte offset
    logic [2:0]          size_q;      // bytes to return
    logic                signed_q;    // sign extend the result
    logic [7:0]          sel_byte;    // byte picked at off_q
    logic [15:0]         sel_half;    // half word picked at off_q
    logic [WB-1:0]       ext_data;    // extended result before misalign zeroing

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
            mis_q   <= 1'b0;
        end else begin
            valid_q <= ld_valid;
            mis_q   <= ld_valid && ld_misaligned;
        end
    end

    // lines up with the word the ram registers on the same edge
    always_ff @(posedge clk) begin
        op_q  <= ld_op;
        off_q <= ld_byte_offset;
    end

    assign size_q   = mem_op_pkg::op_size_bytes(op_q);
    assign signed_q = mem_op_pkg::op_is_signed(op_q);

    assign sel_byte = rdata[8*off_q +: 8];
    assign sel_half = off_q[1] ? rdata[31:16] : rdata[15:0];   // offset 2 takes the upper half

    always_comb begin
        unique case (size_q)
            3'd1:    ext_data = {{(WB-8){signed_q & sel_byte[7]}}, sel_byte};
            3'd2:    ext_data = {{(WB-16){signed_q & sel_half[15]}}, sel_half};
            default: ext_data = rdata;   // word passes as is
        endcase
    end

    // aligned stores stay silent, misaligned ones report
    assign rsp_valid      = valid_q && (mem_op_pkg::op_is_load(op_q) || mis_q);
    assign rsp_misaligned = mis_q;
    assign rsp_rdata      = mis_q ? '0 : ext_data;

endmodule

/* rtl/data_mem_top.sv */
`timescale 1ns/1ps

module data_mem_top #(
    parameter int DEPTH      = mem_geom_pkg::DEF_DEPTH,
    parameter int LINE_WORDS = mem_geom_pkg::DEF_LINE_WORDS,
    localparam int ADDR_W    = $clog2(DEPTH) + $clog2(LINE_WORDS) + mem_geom_pkg::BYTE_OFF_BITS
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               req_valid,
    input  mem_op_pkg::mem_op_t                req_op,
    input  logic [ADDR_W-1:0]                  req_addr,
    input  logic [mem_geom_pkg::WORD_BITS-1:0] req_wdata,
    output logic                               rsp_valid,
    output logic [mem_geom_pkg::WORD_BITS-1:0] rsp_rdata,
    output logic                               rsp_misaligned
);

    mem_req_if #(.DEPTH(DEPTH), .LINE_WORDS(LINE_WORDS)) req_bus ();   // decode to array

    logic                               ld_valid;
    mem_op_pkg::mem_op_t                ld_op;
    logic [1:0]                         ld_byte_offset;
    logic                               ld_misaligned;
    logic [mem_geom_pkg::WORD_BITS-1:0] ram_rdata;        // raw word, one cycle after rd

    access_decode #(.DEPTH(DEPTH), .LINE_WORDS(LINE_WORDS)) u_decode (
        .req_valid      (req_valid),
        .req_op         (req_op),
        .req_addr       (req_addr),
        .req_wdata      (req_wdata),
        .req            (req_bus.decode_mp),
        .ld_valid       (ld_valid),
        .ld_op          (ld_op),
        .ld_byte_offset (ld_byte_offset),
        .ld_misaligned  (ld_misaligned)
    );

    byte_lane_ram #(.DEPTH(DEPTH), .LINE_WORDS(LINE_WORDS)) u_ram (
        .clk   (clk),
        .req   (req_bus.ram_mp),
        .rdata (ram_rdata)
    );

    load_extend u_extend (
        .clk            (clk),
        .reset          (reset),
        .ld_valid       (ld_valid),
        .ld_op          (ld_op),
        .ld_byte_offset (ld_byte_offset),
        .ld_misaligned  (ld_misaligned),
        .rdata          (ram_rdata),
        .rsp_valid      (rsp_valid),
        .rsp_rdata      (rsp_rdata),
        .rsp_misaligned (rsp_misaligned)
    );

endmodule

/* tests/data_mem_model.svh */
`ifndef DATA_MEM_MODEL_SVH
`define DATA_MEM_MODEL_SVH

localparam int MEM_BYTES = 1 << ADDR_W;   // whole array as bytes

logic [7:0]  model_mem [MEM_BYTES];       // little endian byte image of the dut
logic [15:0] lfsr_state = 16'd78;         // fibonacci lfsr, taps 16 14 13 11

// one lfsr step per bit, newest bit ends up at the bottom
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
        fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        r          = {r[30:0], fb};
    end
    return r;
endfunction

function automatic int access_size(input mem_op_pkg::mem_op_t op);
    case (op)
        mem_op_pkg::st_byte, mem_op_pkg::ld_byte_s, mem_op_pkg::ld_byte_u: return 1;
        mem_op_pkg::st_half, mem_op_pkg::ld_half_s, mem_op_pkg::ld_half_u: return 2;
        mem_op_pkg::st_word, mem_op_pkg::ld_word:                          return 4;
        default:                                                           return 0;
    endcase
endfunction

function automatic logic is_store_op(input mem_op_pkg::mem_op_t op);
    return op inside {mem_op_pkg::st_byte, mem_op_pkg::st_half, mem_op_pkg::st_word};
endfunction

function automatic logic is_signed_load(input mem_op_pkg::mem_op_t op);
    return op inside {mem_op_pkg::ld_byte_s, mem_op_pkg::ld_half_s};
endfunction

// half words on even offsets, words on offset zero
function automatic logic misaligned_access(input mem_op_pkg::mem_op_t op,
                                           input logic [ADDR_W-1:0] addr);
    int size;
    size = access_size(op);
    return (size == 2 && addr[0]) || (size == 4 && addr[1:0] != 2'b00);
endfunction

// applies a store to the byte image, predicts the response of the same request
task automatic predict(input mem_op_pkg::mem_op_t op, input logic [ADDR_W-1:0] addr,
                       input logic [31:0] wdata, output logic exp_valid,
                       output logic exp_mis, output logic [31:0] exp_data);
    int          size;
    logic        is_load;
    logic [31:0] value;
    size      = access_size(op);
    is_load   = (op != mem_op_pkg::op_none) && !is_store_op(op);
    exp_mis   = misaligned_access(op, addr);
    exp_valid = is_load || exp_mis;   // aligned stores are silent
    value     = '0;
    if (is_store_op(op) && !exp_mis) begin
        for (int i = 0; i < size; i++) begin
            model_mem[int'(addr) + i] = wdata[8*i +: 8];
        end
    end
    if (is_load && !exp_mis) begin
        for (int i = 0; i < size; i++) begin
            value[8*i +: 8] = model_mem[int'(addr) + i];
        end
        if (is_signed_load(op) && size == 1) value[31:8]  = {24{value[7]}};
        if (is_signed_load(op) && size == 2) value[31:16] = {16{value[15]}};
    end
    exp_data = value;   // zero for stores and misaligned accesses
endtask

`endif

/* tests/data_mem_tb.sv */
`timescale 1ns/1ps

module data_mem_tb;

    localparam int ADDR_W = $clog2(mem_geom_pkg::DEF_DEPTH) + $clog2(mem_geom_pkg::DEF_LINE_WORDS)
                            + mem_geom_pkg::BYTE_OFF_BITS;
    localparam int RSP_TIMEOUT = 8;   // cycles allowed for a response

    logic                clk;
    logic                reset;
    logic                req_valid;
    mem_op_pkg::mem_op_t req_op;
    logic [ADDR_W-1:0]   req_addr;
    logic [31:0]         req_wdata;
    logic                rsp_valid;
    logic [31:0]         rsp_rdata;
    logic                rsp_misaligned;
    int                  checks = 0;
    int                  errors = 0;
    int                  test_errors = 0;   // error count when the current test began

    `include "data_mem_model.svh"

    data_mem_top u_dut (
        .clk            (clk),
        .reset          (reset),
        .req_valid      (req_valid),
        .req_op         (req_op),
        .req_addr       (req_addr),
        .req_wdata      (req_wdata),
        .rsp_valid      (rsp_valid),
        .rsp_rdata      (rsp_rdata),
        .rsp_misaligned (rsp_misaligned)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;   // 40 ns period
    end

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Mismatch at %0d ns: %s got %h expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic check_response(input logic exp_valid, input logic exp_mis,
                                  input logic [31:0] exp_data);
        check_value("rsp_valid", rsp_valid, exp_valid);
        if (exp_valid) begin
            check_value("rsp_rdata", rsp_rdata, exp_data);
            check_value("rsp_misaligned", rsp_misaligned, exp_mis);
        end
    endtask

    task automatic end_test(input string name);
        $display("test %s: %0d errors", name, errors - test_errors);
        test_errors = errors;
    endtask

    // drives one request and idles until its response shows up
    task automatic run_access(input mem_op_pkg::mem_op_t op, input logic [ADDR_W-1:0] addr,
                              input logic [31:0] wdata);
        logic        exp_valid;
        logic        exp_mis;
        logic [31:0] exp_data;
        int          cycles;
        predict(op, addr, wdata, exp_valid, exp_mis, exp_data);
        req_valid = 1'b1;
        req_op    = op;
        req_addr  = addr;
        req_wdata = wdata;
        @(posedge clk);
        #2;
        req_valid = 1'b0;
        req_op    = mem_op_pkg::op_none;
        cycles    = 1;
        while (exp_valid && rsp_valid !== 1'b1 && cycles < RSP_TIMEOUT) begin
            @(posedge clk);
            #2;
            cycles++;
        end
        if (exp_valid && rsp_valid !== 1'b1) begin
            errors++;
            $display("no response within %0d cycles to %s at address %h",
                     RSP_TIMEOUT, op.name(), addr);
        end else begin
            if (exp_valid) begin
                check_value("response latency", cycles, 1);
            end
            check_response(exp_valid, exp_mis, exp_data);
        end
    endtask

    initial begin
        logic [ADDR_W-1:0]   addr;
        logic [ADDR_W-1:0]   addr_q [$];   // word addresses stored in the word test
        logic [31:0]         wdata;
        logic [9:0]          w;
        mem_op_pkg::mem_op_t op;
        logic                exp_valid;
        logic                exp_mis;
        logic [31:0]         exp_data;
        reset     = 1'b1;
        req_valid = 1'b0;
        req_op    = mem_op_pkg::op_none;
        req_addr  = '0;
        req_wdata = '0;
        repeat (4) @(posedge clk);
        #2;
        reset = 1'b0;

        check_value("rsp_valid after reset", rsp_valid, 1'b0);
        check_value("rsp_misaligned after reset", rsp_misaligned, 1'b0);
        repeat (6) begin
            @(posedge clk);
            #2;
            check_value("rsp_valid while idle", rsp_valid, 1'b0);
        end
        end_test("reset and idle");

        for (int i = 0; i < MEM_BYTES / 4; i++) begin   // define every word first
            w = i[9:0];
            run_access(mem_op_pkg::st_word, ADDR_W'(i * 4), {w, 6'h2d, ~w, w[9:4]});
        end
        repeat (24) begin
            addr = {(ADDR_W-2)'(rand_bits(ADDR_W - 2)), 2'b00};
            addr_q.push_back(addr);
            run_access(mem_op_pkg::st_word, addr, rand_bits(32));
        end
        foreach (addr_q[i]) begin
            run_access(mem_op_pkg::ld_word, addr_q[i], '0);
        end
        end_test("word store and load");

        repeat (80) begin   // all sizes packed into one 16 byte row so they merge
            op   = mem_op_pkg::mem_op_t'(4'd1 + 4'(rand_bits(3)));
            addr = ADDR_W'(12'h3c0) | ADDR_W'(rand_bits(4));
            if (access_size(op) == 2) addr[0] = 1'b0;
            if (access_size(op) == 4) addr[1:0] = 2'b00;
            run_access(op, addr, rand_bits(32));
        end
        end_test("byte and half word merge");

        repeat (20) begin
            case (rand_bits(3) % 5)
                0:       op = mem_op_pkg::st_half;
                1:       op = mem_op_pkg::st_word;
                2:       op = mem_op_pkg::ld_half_s;
                3:       op = mem_op_pkg::ld_half_u;
                default: op = mem_op_pkg::ld_word;
            endcase
            addr = ADDR_W'(rand_bits(ADDR_W));
            if (access_size(op) == 2) addr[0] = 1'b1;              // odd offset
            else if (addr[1:0] == 2'b00) addr[1:0] = 2'b10;        // any nonzero offset
            run_access(op, addr, rand_bits(32));
            run_access(mem_op_pkg::ld_word, {addr[ADDR_W-1:2], 2'b00}, '0);   // word unchanged
        end
        end_test("misaligned access");

        repeat (300) begin   // one request per cycle with each response due on the next edge
            op    = mem_op_pkg::mem_op_t'(4'd1 + 4'(rand_bits(3)));
            addr  = ADDR_W'(rand_bits(ADDR_W));
            wdata = rand_bits(32);
            predict(op, addr, wdata, exp_valid, exp_mis, exp_data);
            req_valid = 1'b1;
            req_op    = op;
            req_addr  = addr;
            req_wdata = wdata;
            @(posedge clk);
            #2;
            check_response(exp_valid, exp_mis, exp_data);
        end
        req_valid = 1'b0;
        req_op    = mem_op_pkg::op_none;
        end_test("back to back random mix");

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* src.f */
rtl/mem_geom_pkg.sv
rtl/mem_op_pkg.sv
rtl/mem_req_if.sv
rtl/access_decode.sv
rtl/byte_lane_ram.sv
rtl/load_extend.sv
rtl/data_mem_top.sv
+incdir+tests
tests/data_mem_tb.sv
